// File: burstCounter.sv
// Burst down-counter
`default_nettype none

module burstCounter
  import clkPkg::*;
(
  input  wire logic       CLK,
  input  wire logic       rst,
  input  wire funcPulsesT funcs,
  input  wire busDataT    diagData,
  input  wire ctrlRegsT   ctrl,
  input  wire logic       gateTick,
  output burstCountT      count,
  output logic            burstZero
);

  logic countDown;

  assign burstZero = (count == '0);

  // Only ticks issued in burst mode use up the count
  assign countDown = ctrl.burstMode & gateTick & ~burstZero;

  always_ff @(posedge CLK) begin
    if (rst) begin
      count <= '0;
    end else begin
      // Nibble loads win over a tick in the same cycle
      if (funcs.ld042 || funcs.ld043) begin
        if (funcs.ld042) begin
          count[3:0] <= diagData;
        end
        if (funcs.ld043) begin
          count[7:4] <= diagData;
        end
      end else if (countDown) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: clkBoard.sv
// Clock board top level
`default_nettype none

module clkBoard
  import clkPkg::*;
(
  input  wire logic      CLK,
  input  wire logic      rst,
  input  wire diagSelT   diagSel,
  input  wire busDataT   diagData,
  input  wire logic      diagCtlFunc,
  input  wire logic      diagLdFunc,
  input  wire logic      diagRead,
  input  wire timeFieldT timeField,
  input  wire logic      mboxWait,
  input  wire logic      mboxResp,
  input  wire logic      setPageFail,
  output readWordT       readData,
  output logic           readDrive,
  output logic           eboxTick,
  output logic           crmClk,
  output logic           edpClk,
  output logic           ctlClk,
  output logic           eboxCycAbort
);

  funcPulsesT funcPulses;
  ctrlRegsT ctrl;
  burstCountT count;
  logic burstZero;
  logic gateTick;
  runStateT runState;
  pageFailT pf;
  logic syncFlag;
  logic eboxClk;

  diagFuncDecode uDecode (
    .CLK(CLK), .rst(rst), .diagSel(diagSel), .diagCtlFunc(diagCtlFunc),
    .diagLdFunc(diagLdFunc), .funcs(funcPulses)
  );

  clkCtrlRegs uRegs (
    .CLK(CLK), .rst(rst), .funcs(funcPulses), .diagData(diagData), .ctrl(ctrl)
  );

  burstCounter uBurst (
    .CLK(CLK), .rst(rst), .funcs(funcPulses), .diagData(diagData), .ctrl(ctrl),
    .gateTick(gateTick), .count(count), .burstZero(burstZero)
  );

  clockGate uGate (
    .CLK(CLK), .rst(rst), .ctrl(ctrl), .funcs(funcPulses), .burstZero(burstZero),
    .gateTick(gateTick), .runState(runState)
  );

  eboxSync uSync (
    .CLK(CLK), .rst(rst), .ctrl(ctrl), .gateTick(gateTick), .mboxWait(mboxWait),
    .mboxResp(mboxResp), .setPageFail(setPageFail), .timeField(timeField),
    .eboxTick(eboxTick), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
    .eboxCycAbort(eboxCycAbort), .syncFlag(syncFlag), .eboxClk(eboxClk), .pf(pf)
  );

  diagReadback uReadback (
    .diagRead(diagRead), .diagSel(diagSel), .ctrl(ctrl), .count(count),
    .runState(runState), .syncFlag(syncFlag), .eboxClk(eboxClk), .pf(pf),
    .readData(readData), .readDrive(readDrive)
  );

endmodule

`default_nettype wire

// File: clkChecker.sv
// Clock board result checker
`default_nettype none

module clkChecker
  import clkPkg::*;
(
  input  wire logic        CLK,
  input  wire readWordT    readData,
  input  wire logic        readDrive,
  input  wire logic        eboxTick,
  input  wire logic        crmClk,
  input  wire logic        edpClk,
  input  wire logic        ctlClk,
  input  wire logic        eboxCycAbort,
  input  wire logic        checkRead,
  input  wire logic        checkPulses,
  input  wire logic        clearCounts,
  input  wire logic [2:0]  checkSel,
  input  wire logic [7:0]  expectVal,
  input  wire logic [3:0]  testId,
  input  wire logic [15:0] entry,
  input  wire logic [2:0]  sectionDis,
  input  wire logic        reportReq,
  output int               errorCount
);

  timeunit 1ns;
  timeprecision 1ps;

  int errors = 0;
  int checks = 0;
  int tickCount = 0;
  int crmCount = 0;
  int edpCount = 0;
  int abortCount = 0;
  int seen;
  logic abortLast = 1'b0;
  logic reported = 1'b0;

  assign errorCount = errors;

  function automatic string testName(input logic [3:0] id);
    case (id)
      4'd1: return "register round trip";
      4'd2: return "burst count load";
      4'd3: return "burst run";
      4'd4: return "single step";
      4'd5: return "page fail";
      4'd6: return "section disable";
      default: return "trace";
    endcase
  endfunction

  function automatic string counterName(input logic [2:0] sel);
    case (sel)
      3'd0: return "eboxTick";
      3'd1: return "crmClk";
      3'd2: return "edpClk";
      default: return "eboxCycAbort";
    endcase
  endfunction

  // A section clock pulses with eboxTick unless its section is disabled
  task automatic checkSection(input string name, input logic clk, input logic disabled);
    logic expected;
    expected = eboxTick && !disabled;
    if (clk !== expected) begin
      errors = errors + 1;
      $display("FAILED %s, entry %0d %s: expected %b, actual %b",
               testName(testId), entry, name, expected, clk);
    end
  endtask

  // Sampled mid-cycle away from the driving edge
  always @(negedge CLK) begin
    abortLast <= eboxCycAbort;
    if (clearCounts) begin
      tickCount <= 0;
      crmCount <= 0;
      edpCount <= 0;
      abortCount <= 0;
    end else begin
      if (eboxTick) tickCount <= tickCount + 1;
      if (crmClk) crmCount <= crmCount + 1;
      if (edpClk) edpCount <= edpCount + 1;
      // Abort is a level so only its onsets count
      if (eboxCycAbort && !abortLast) abortCount <= abortCount + 1;
    end

    checkSection("crmClk", crmClk, sectionDis[2]);
    checkSection("edpClk", edpClk, sectionDis[1]);
    checkSection("ctlClk", ctlClk, sectionDis[0]);

    if (checkRead) begin
      checks = checks + 1;
      if (!readDrive) begin
        errors = errors + 1;
        $display("Entry %0d: readDrive stayed low during a read", entry);
      end
      if ({2'b00, readData} !== expectVal) begin
        errors = errors + 1;
        $display("FAILED %s, entry %0d select %0d: expected %h, actual %h",
                 testName(testId), entry, checkSel, expectVal[5:0], readData);
      end
    end

    if (checkPulses) begin
      checks = checks + 1;
      case (checkSel)
        3'd0: seen = tickCount;
        3'd1: seen = crmCount;
        3'd2: seen = edpCount;
        default: seen = abortCount;
      endcase
      if (seen != int'(expectVal)) begin
        errors = errors + 1;
        $display("FAILED %s, entry %0d %s count: expected %0d, actual %0d",
                 testName(testId), entry, counterName(checkSel), expectVal, seen);
      end
    end

    if (reportReq && !reported) begin
      reported <= 1'b1;
      $display("Checks run: %0d, errors: %0d", checks, errors);
    end
  end

endmodule

`default_nettype wire

// File: clkCtrlRegs.sv
// Clock control registers
`default_nettype none

module clkCtrlRegs
  import clkPkg::*;
(
  input  wire logic       CLK,
  input  wire logic       rst,
  input  wire funcPulsesT funcs,
  input  wire busDataT    diagData,
  output ctrlRegsT        ctrl
);

  always_ff @(posedge CLK) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      // Function 044, source and rate select
      if (funcs.ld044) begin
        ctrl.sourceSel <= diagData[3:2];
        ctrl.rateSel <= diagData[1:0];
      end

      // Function 045, section disables in the low three bits
      if (funcs.ld045) begin
        ctrl.crmDis <= diagData[2];
        ctrl.edpDis <= diagData[1];
        ctrl.ctlDis <= diagData[0];
      end

      if (funcs.ld046) begin
        ctrl.fmParCheck <= diagData[3];
        ctrl.cramParCheck <= diagData[2];
        ctrl.dramParCheck <= diagData[1];
        ctrl.fsCheck <= diagData[0];
      end

      if (funcs.ld047) begin
        ctrl.mboxCycleDis <= diagData[3];
        ctrl.respSim <= diagData[2];
        ctrl.arArxParCheck <= diagData[1];
        ctrl.errStopEn <= diagData[0];
      end

      // Run modes are mutually exclusive
      if (funcs.start) begin
        ctrl.go <= 1'b1;
        ctrl.burstMode <= 1'b0;
        ctrl.eboxSs <= 1'b0;
      end else if (funcs.burst) begin
        ctrl.go <= 1'b0;
        ctrl.burstMode <= 1'b1;
        ctrl.eboxSs <= 1'b0;
      end else if (funcs.eboxSs) begin
        ctrl.go <= 1'b0;
        ctrl.burstMode <= 1'b0;
        ctrl.eboxSs <= 1'b1;
      end

      if (funcs.clrReset) begin
        ctrl.resetFF <= 1'b1;
      end else if (funcs.setReset) begin
        ctrl.resetFF <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: clkPkg.sv
// Clock board shared types and codes
`default_nettype none

package clkPkg;

  localparam int BURST_W = 8;
  localparam int DIV_W = 3;

  typedef logic [2:0] diagSelT;
  // Bus bits 32 to 35, bit 3 carries bus bit 32
  typedef logic [3:0] busDataT;
  typedef logic [BURST_W-1:0] burstCountT;
  typedef logic [5:0] readWordT;
  typedef logic [1:0] timeFieldT;
  typedef logic [1:0] phaseCountT;

  // Select that touches no register
  localparam diagSelT RESET_SEL = 3'd0;

  // Control functions, decoded under diagCtlFunc
  localparam diagSelT FN_START = 3'd1;
  localparam diagSelT FN_SINGLE_STEP = 3'd2;
  localparam diagSelT FN_EBOX_SS = 3'd3;
  localparam diagSelT FN_COND_SS = 3'd4;
  localparam diagSelT FN_BURST = 3'd5;
  localparam diagSelT FN_CLR_RESET = 3'd6;
  localparam diagSelT FN_SET_RESET = 3'd7;

  // Load functions 042 to 047, decoded under diagLdFunc
  localparam diagSelT FN_LD042 = 3'd2;
  localparam diagSelT FN_LD043 = 3'd3;
  localparam diagSelT FN_LD044 = 3'd4;
  localparam diagSelT FN_LD045 = 3'd5;
  localparam diagSelT FN_LD046 = 3'd6;
  localparam diagSelT FN_LD047 = 3'd7;

  typedef struct packed {
    logic start;
    logic singleStep;
    logic eboxSs;
    logic condSs;
    logic burst;
    logic clrReset;
    logic setReset;
    logic ld042;
    logic ld043;
    logic ld044;
    logic ld045;
    logic ld046;
    logic ld047;
  } funcPulsesT;

  typedef struct packed {
    logic [1:0] sourceSel;
    logic [1:0] rateSel;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
    logic fmParCheck;
    logic cramParCheck;
    logic dramParCheck;
    logic fsCheck;
    logic mboxCycleDis;
    logic respSim;
    logic arArxParCheck;
    logic errStopEn;
    logic go;
    logic burstMode;
    logic eboxSs;
    logic resetFF;
  } ctrlRegsT;

  typedef struct packed {
    logic pfDlydA;
    logic pfDlydB;
    logic force1777;
    logic sbrCall;
    logic instr1777;
    logic pageFailEn;
  } pageFailT;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    BURST,
    STEP
  } runStateT;

endpackage

`default_nettype wire

// File: clk_trace.txt
// Word is test_op_sel_data_expect, op 0 ctl 1 ld 2 read 3 wait 4 pulses 5 level 6 clear F end
// Data is a load nibble, ctl repeat count, wait cycles or levels {resp,wait,pf,time[1:0]}
1_1_4_00B_00  // 044 source 2, rate 3
1_1_5_005_00  // 045 crm and ctl disabled
1_1_6_00A_00  // 046 checks
1_1_7_006_00  // 047 misc bits
1_2_4_000_18
1_2_5_000_06
1_2_6_000_08
1_2_7_000_2F
2_1_2_005_00  // 042 low nibble
2_1_3_00C_00  // 043 high nibble
2_2_0_000_03
2_2_1_000_05
3_1_4_000_00  // rate back to every cycle
3_1_5_000_00
3_1_7_000_00
3_5_0_000_00  // time field 0 matches every tick
3_1_2_005_00  // burst of 5
3_1_3_000_00
3_6_0_000_00
3_0_5_001_00  // burst function
3_3_0_014_00
3_4_0_000_05
3_4_1_000_05
3_2_0_000_00
3_2_1_000_00
3_2_3_000_04
4_0_3_001_00  // ebox single step mode
4_6_0_000_00
4_0_2_003_00  // three single steps
4_3_0_004_00
4_4_0_000_03
4_2_3_000_14
6_1_5_002_00  // edp disabled
6_6_0_000_00
6_0_2_002_00
6_3_0_004_00
6_4_1_000_02
6_4_2_000_00
5_5_0_004_00  // page fail request high
5_6_0_000_00
5_0_2_001_00
5_5_0_000_00  // request low again
5_0_2_004_00  // walk the chain to the trap tick
5_3_0_004_00
5_4_3_000_02
5_4_0_000_01
5_2_3_000_17
5_2_0_000_08
5_2_2_000_14
0_F_0_000_00

// File: clockGate.sv
// Rate divider and processor clock gate
`default_nettype none

module clockGate
  import clkPkg::*;
(
  input  wire logic       CLK,
  input  wire logic       rst,
  input  wire ctrlRegsT   ctrl,
  input  wire funcPulsesT funcs,
  input  wire logic       burstZero,
  output logic            gateTick,
  output runStateT        runState
);

  logic [DIV_W-1:0] divCount;
  logic [DIV_W-1:0] rateMask;
  logic ratePulse;
  logic tickSeen;

  // Spacing of 2 ** rateSel cycles
  always_comb begin
    case (ctrl.rateSel)
      2'd0: rateMask = 3'b000;
      2'd1: rateMask = 3'b001;
      2'd2: rateMask = 3'b011;
      default: rateMask = 3'b111;
    endcase
  end

  assign ratePulse = ((divCount & rateMask) == rateMask);

  always_comb begin
    case (runState)
      RUN: gateTick = ratePulse & ctrl.go;
      BURST: gateTick = ratePulse & ~burstZero;
      STEP: gateTick = ratePulse;
      default: gateTick = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      divCount <= '0;
      tickSeen <= 1'b0;
      runState <= IDLE;
    end else begin
      divCount <= divCount + 1'b1;

      // Stands in for the processor clock history on cond step
      if (gateTick && runState == STEP) begin
        tickSeen <= 1'b0;
      end else if (gateTick) begin
        tickSeen <= 1'b1;
      end

      case (runState)
        IDLE: begin
          if (ctrl.go) begin
            runState <= RUN;
          end else if (ctrl.burstMode && !burstZero) begin
            runState <= BURST;
          end else if (funcs.singleStep || (funcs.condSs && tickSeen)) begin
            runState <= STEP;
          end
        end
        RUN: if (!ctrl.go) runState <= IDLE;
        BURST: if (burstZero || !ctrl.burstMode) runState <= IDLE;
        STEP: if (ratePulse) runState <= IDLE;
        default: runState <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: diagFuncDecode.sv
// Diagnostic function decode
`default_nettype none

module diagFuncDecode
  import clkPkg::*;
(
  input  wire logic    CLK,
  input  wire logic    rst,
  input  wire diagSelT diagSel,
  input  wire logic    diagCtlFunc,
  input  wire logic    diagLdFunc,
  output funcPulsesT   funcs
);

  funcPulsesT decoded;

  always_comb begin
    decoded = '0;
    if (diagCtlFunc) begin
      case (diagSel)
        RESET_SEL: ;
        FN_START: decoded.start = 1'b1;
        FN_SINGLE_STEP: decoded.singleStep = 1'b1;
        FN_EBOX_SS: decoded.eboxSs = 1'b1;
        FN_COND_SS: decoded.condSs = 1'b1;
        FN_BURST: decoded.burst = 1'b1;
        FN_CLR_RESET: decoded.clrReset = 1'b1;
        FN_SET_RESET: decoded.setReset = 1'b1;
      endcase
    end
    // Load selects 0 and 1 have no function
    if (diagLdFunc) begin
      case (diagSel)
        FN_LD042: decoded.ld042 = 1'b1;
        FN_LD043: decoded.ld043 = 1'b1;
        FN_LD044: decoded.ld044 = 1'b1;
        FN_LD045: decoded.ld045 = 1'b1;
        FN_LD046: decoded.ld046 = 1'b1;
        FN_LD047: decoded.ld047 = 1'b1;
        default: ;
      endcase
    end
  end

  // One strobe cycle gives one pulse cycle
  always_ff @(posedge CLK) begin
    if (rst) begin
      funcs <= '0;
    end else begin
      funcs <= decoded;
    end
  end

endmodule

`default_nettype wire

// File: diagReadback.sv
// Diagnostic readback mux
`default_nettype none

module diagReadback
  import clkPkg::*;
(
  input  wire logic       diagRead,
  input  wire diagSelT    diagSel,
  input  wire ctrlRegsT   ctrl,
  input  wire burstCountT count,
  input  wire runStateT   runState,
  input  wire logic       syncFlag,
  input  wire logic       eboxClk,
  input  wire pageFailT   pf,
  output readWordT        readData,
  output logic            readDrive
);

  logic pageError;
  logic running;

  assign pageError = pf.pageFailEn | pf.instr1777;
  // Stands in for the clock-on level in word 0
  assign running = (runState != IDLE);

  assign readDrive = diagRead;

  // Word layout follows the board, dropped bits read as zero
  always_comb begin
    readData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: readData = {running, 1'b0, pf.instr1777, 1'b0, count[7:6]};
        3'd1: readData = count[5:0];
        3'd2: readData = {1'b0, ~ctrl.go, 1'b0, syncFlag, pf.pageFailEn, pf.force1777};
        3'd3: readData = {1'b0, ~ctrl.burstMode, 1'b0, ~eboxClk, pageError, pf.instr1777};
        3'd4: readData = {1'b0, ~ctrl.eboxSs, ctrl.sourceSel[1], 1'b0,
                          ~ctrl.fmParCheck, ctrl.mboxCycleDis};
        3'd5: readData = {1'b0, 1'b0, ctrl.sourceSel[0], ctrl.crmDis,
                          ~ctrl.cramParCheck, ~ctrl.respSim};
        3'd6: readData = {1'b0, 1'b0, ctrl.rateSel[1], ctrl.edpDis,
                          ~ctrl.dramParCheck, ~ctrl.arArxParCheck};
        // Top bit is the inverted error level, always clear here
        default: readData = {1'b1, 1'b0, ctrl.rateSel[0], ctrl.ctlDis,
                             ~ctrl.fsCheck, ~ctrl.errStopEn};
      endcase
    end
  end

endmodule

`default_nettype wire

// File: eboxSync.sv
// Phase sync, section clocks and page fail
`default_nettype none

module eboxSync
  import clkPkg::*;
(
  input  wire logic      CLK,
  input  wire logic      rst,
  input  wire ctrlRegsT  ctrl,
  input  wire logic      gateTick,
  input  wire logic      mboxWait,
  input  wire logic      mboxResp,
  input  wire logic      setPageFail,
  input  wire timeFieldT timeField,
  output logic           eboxTick,
  output logic           crmClk,
  output logic           edpClk,
  output logic           ctlClk,
  output logic           eboxCycAbort,
  output logic           syncFlag,
  output logic           eboxClk,
  output pageFailT       pf
);

  phaseCountT phase;
  logic syncFound;
  logic stall;
  logic eboxSrcEn;
  logic chainBusy;
  logic pageFail;

  // Single step mode ignores the time field
  assign syncFound = (phase == timeField) | ctrl.eboxSs;
  assign stall = mboxWait & ~(mboxResp | ctrl.respSim);
  assign eboxSrcEn = gateTick & syncFound & ~stall & ~ctrl.resetFF;

  // Ticks are held off until the chain reaches the sbrCall stage
  assign chainBusy = pf.pfDlydA | pf.pfDlydB | pf.force1777;
  assign pageFail = setPageFail & eboxSrcEn & ~chainBusy & ~pf.sbrCall;
  assign eboxTick = eboxSrcEn & ~pageFail & ~chainBusy;

  assign crmClk = eboxTick & ~ctrl.crmDis;
  assign edpClk = eboxTick & ~ctrl.edpDis;
  assign ctlClk = eboxTick & ~ctrl.ctlDis;
  assign eboxCycAbort = pageFail | pf.pfDlydB;

  always_ff @(posedge CLK) begin
    if (rst) begin
      phase <= '0;
      syncFlag <= 1'b0;
      eboxClk <= 1'b0;
      pf <= '0;
    end else begin
      syncFlag <= syncFound;
      eboxClk <= eboxTick;

      // Phase restarts on each processor tick
      if (gateTick) begin
        phase <= eboxTick ? phaseCountT'(0) : phase + 2'd1;
        pf.pfDlydA <= pageFail;
        pf.pfDlydB <= pf.pfDlydA;
        pf.force1777 <= pf.pfDlydB;
      end

      if (gateTick && pf.force1777) begin
        pf.sbrCall <= 1'b1;
      end else if (eboxTick) begin
        pf.sbrCall <= 1'b0;
      end

      // Trap tick sets it, the next plain tick clears it
      if (eboxTick) begin
        pf.instr1777 <= pf.sbrCall;
      end

      if (pageFail) begin
        pf.pageFailEn <= 1'b1;
      end else if (eboxTick && pf.sbrCall) begin
        pf.pageFailEn <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
clkPkg.sv
diagFuncDecode.sv
clkCtrlRegs.sv
burstCounter.sv
clockGate.sv
eboxSync.sv
diagReadback.sv
clkBoard.sv
clkChecker.sv
tb_clkBoard.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the clock board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module tb_clkBoard -o simClkBoard
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/simClkBoard)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// File: tb_clkBoard.sv
// Clock board testbench
`default_nettype none

module tb_clkBoard
  import clkPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TRACE_DEPTH = 64;
  localparam logic [3:0] OP_CTL = 4'h0;
  localparam logic [3:0] OP_LD = 4'h1;
  localparam logic [3:0] OP_READ = 4'h2;
  localparam logic [3:0] OP_WAIT = 4'h3;
  localparam logic [3:0] OP_PULSES = 4'h4;
  localparam logic [3:0] OP_LEVEL = 4'h5;
  localparam logic [3:0] OP_CLEAR = 4'h6;
  localparam logic [3:0] OP_END = 4'hF;

  logic CLK;
  logic rst;
  diagSelT diagSel;
  busDataT diagData;
  logic diagCtlFunc;
  logic diagLdFunc;
  logic diagRead;
  timeFieldT timeField;
  logic mboxWait;
  logic mboxResp;
  logic setPageFail;
  readWordT readData;
  logic readDrive;
  logic eboxTick;
  logic crmClk;
  logic edpClk;
  logic ctlClk;
  logic eboxCycAbort;

  // Checker control
  logic checkRead;
  logic checkPulses;
  logic clearCounts;
  logic reportReq;
  logic [2:0] checkSel;
  logic [7:0] expectVal;
  logic [3:0] curTest;
  logic [15:0] curEntry;
  // Section disables as last loaded by function 045, crm on top
  logic [2:0] sectionDis;
  int errorCount;

  logic [31:0] traceMem [0:TRACE_DEPTH-1];
  int idx;
  int cycleLimit = 0;
  int cycleCount = 0;
  logic traceOk;

  clkBoard UUT (
    .CLK(CLK), .rst(rst), .diagSel(diagSel), .diagData(diagData),
    .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc), .diagRead(diagRead),
    .timeField(timeField), .mboxWait(mboxWait), .mboxResp(mboxResp),
    .setPageFail(setPageFail), .readData(readData), .readDrive(readDrive),
    .eboxTick(eboxTick), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
    .eboxCycAbort(eboxCycAbort)
  );

  clkChecker uChecker (
    .CLK(CLK), .readData(readData), .readDrive(readDrive), .eboxTick(eboxTick),
    .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk), .eboxCycAbort(eboxCycAbort),
    .checkRead(checkRead), .checkPulses(checkPulses), .clearCounts(clearCounts),
    .checkSel(checkSel), .expectVal(expectVal), .testId(curTest), .entry(curEntry),
    .sectionDis(sectionDis), .reportReq(reportReq), .errorCount(errorCount)
  );

  always #4 CLK = ~CLK;

  // Worst case length of the trace in cycles
  function automatic int traceCycles();
    int total;
    int n;
    total = 100;
    for (n = 0; n < TRACE_DEPTH; n++) begin
      if (traceMem[n][27:24] == OP_WAIT) begin
        total += int'(traceMem[n][19:8]);
      end else if (traceMem[n][27:24] == OP_CTL) begin
        total += 3 * int'(traceMem[n][19:8]) + 3;
      end else begin
        total += 3;
      end
    end
    return total;
  endfunction

  // Strobe held one cycle and then two cycles until the write is visible
  task automatic strobeFunction(input logic isLoad, input diagSelT sel,
                                input busDataT nibble, input int reps);
    int n;
    for (n = 0; n < reps; n++) begin
      @(posedge CLK);
      diagSel <= sel;
      diagData <= nibble;
      diagCtlFunc <= ~isLoad;
      diagLdFunc <= isLoad;
      @(posedge CLK);
      diagCtlFunc <= 1'b0;
      diagLdFunc <= 1'b0;
      @(posedge CLK);
    end
  endtask

  task automatic readWord(input diagSelT sel, input logic [7:0] value);
    @(posedge CLK);
    diagSel <= sel;
    diagRead <= 1'b1;
    checkSel <= sel;
    expectVal <= value;
    checkRead <= 1'b1;
    @(posedge CLK);
    diagRead <= 1'b0;
    checkRead <= 1'b0;
  endtask

  task automatic checkWindow(input logic [2:0] sel, input logic [7:0] value);
    @(posedge CLK);
    checkSel <= sel;
    expectVal <= value;
    checkPulses <= 1'b1;
    @(posedge CLK);
    checkPulses <= 1'b0;
  endtask

  task automatic clearWindow();
    @(posedge CLK);
    clearCounts <= 1'b1;
    @(posedge CLK);
    clearCounts <= 1'b0;
  endtask

  // Bits from the top are resp, wait and page fail over the time field
  task automatic setLevels(input logic [4:0] bits);
    @(posedge CLK);
    timeField <= bits[1:0];
    setPageFail <= bits[2];
    mboxWait <= bits[3];
    mboxResp <= bits[4];
  endtask

  task automatic runLine(input logic [31:0] word, input int num);
    logic [3:0] op;
    diagSelT sel;
    logic [11:0] data;
    logic [7:0] value;
    op = word[27:24];
    sel = word[22:20];
    data = word[19:8];
    value = word[7:0];
    curTest <= word[31:28];
    curEntry <= num[15:0];
    case (op)
      OP_CTL: strobeFunction(1'b0, sel, data[3:0], int'(data));
      OP_LD: begin
        strobeFunction(1'b1, sel, data[3:0], 1);
        // Disables are live once the load is visible
        if (sel == FN_LD045) begin
          sectionDis <= data[2:0];
        end
      end
      OP_READ: readWord(sel, value);
      OP_WAIT: repeat (int'(data)) @(posedge CLK);
      OP_PULSES: checkWindow(sel, value);
      OP_LEVEL: setLevels(data[4:0]);
      OP_CLEAR: clearWindow();
      default: begin
        traceOk = 1'b0;
        $display("Trace entry %0d has an unknown operation %h", num, op);
      end
    endcase
  endtask

  initial begin
    CLK = 1'b0;
    rst = 1'b1;
    diagSel = '0;
    diagData = '0;
    diagCtlFunc = 1'b0;
    diagLdFunc = 1'b0;
    diagRead = 1'b0;
    timeField = '0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    setPageFail = 1'b0;
    checkRead = 1'b0;
    checkPulses = 1'b0;
    clearCounts = 1'b0;
    reportReq = 1'b0;
    checkSel = '0;
    expectVal = '0;
    curTest = '0;
    curEntry = '0;
    sectionDis = '0;
    traceOk = 1'b1;
    for (idx = 0; idx < TRACE_DEPTH; idx++) begin
      traceMem[idx] = '1;
    end
    $readmemh("clk_trace.txt", traceMem);
    cycleLimit = traceCycles();

    repeat (2) @(posedge CLK);
    rst <= 1'b0;

    idx = 0;
    while (idx < TRACE_DEPTH && traceMem[idx][27:24] != OP_END) begin
      runLine(traceMem[idx], idx + 1);
      idx++;
    end

    repeat (2) @(posedge CLK);
    reportReq <= 1'b1;
    @(posedge CLK);
    if (errorCount == 0 && traceOk) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge CLK);
      cycleCount = cycleCount + 1;
    end
    $display("Timeout, the trace was still running after %0d cycles", cycleLimit);
    reportReq <= 1'b1;
    @(posedge CLK);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
